//--- source/frame_consts.svh
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// xgmii lane widths
`define NB_DATA_RAW	64
`define NB_CTRL_RAW	8

// descriptor field widths
`define NB_TERM		3
`define NB_NDATA	8
`define NB_NIDLE	5
`define NB_NOISE	16

// clamp limit on payload words
`define NDATA_MAX	8'd189

// xgmii characters
`define CH_START	8'hFB
`define CH_PRE		8'h55
`define CH_SFD		8'hD5
`define CH_TERM		8'hFD
`define CH_IDLE		8'h07

// generator states
`define ST_WAIT		3'd0
`define ST_START	3'd1
`define ST_DATA		3'd2
`define ST_TERM		3'd3
`define ST_IDLE		3'd4

// lfsr start value, never zero
`define LFSR_SEED	16'hACE1

`endif

//--- source/frame_pkg.sv
`default_nettype none

`include "frame_consts.svh"

package frame_pkg;

	// noise word seen as the raw lfsr state or as descriptor fields
	typedef struct packed {
		logic [`NB_NDATA-1:0]	n_data;	// upper byte
		logic [`NB_NIDLE-1:0]	n_idle;	// next 5 bits
		logic [`NB_TERM-1:0]	n_term;	// lowest 3 bits
	} noise_fields_t;

	typedef union packed {
		logic [`NB_NOISE-1:0]	raw;	// shift register view
		noise_fields_t			fields;	// shaper view
	} noise_word_u;

endpackage

`default_nettype wire

//--- source/noise_lfsr.sv
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module noise_lfsr
	import frame_pkg::*;
(
	input  wire				i_clock,
	input  wire				i_rst_n,
	input  wire				i_ready,
	output logic			o_valid,
	output noise_word_u		o_word
);

	logic [`NB_NOISE-1:0]	lfsr_q;
	logic					feedback;
	logic					step;

	// taps 16,14,13,11 give the full 2^16-1 sequence
	assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

	assign step = o_valid & i_ready;	// one shift per transfer

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b1;	// free running once out of reset
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lfsr_q <= `LFSR_SEED;
		end else if (step) begin
			lfsr_q <= {lfsr_q[14:0], feedback};
		end
	end

	always_comb begin
		o_word.raw = lfsr_q;	// fields view is read downstream
	end

endmodule

`default_nettype wire

//--- source/frame_param_shaper.sv
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module frame_param_shaper
	import frame_pkg::*;
(
	input  wire							i_clock,
	input  wire							i_rst_n,
	input  wire							i_auto,
	input  wire							i_noise_valid,
	input  noise_word_u					i_noise_word,
	input  wire							i_desc_valid,
	input  wire	[`NB_NDATA-1:0]			i_desc_n_data,
	input  wire	[`NB_NIDLE-1:0]			i_desc_n_idle,
	input  wire	[`NB_TERM-1:0]			i_desc_n_term,
	input  wire							i_ready,
	output logic						o_noise_ready,
	output logic						o_desc_ready,
	output logic						o_valid,
	output logic [`NB_NDATA-1:0]		o_n_data,
	output logic [`NB_NIDLE-1:0]		o_n_idle,
	output logic [`NB_TERM-1:0]			o_n_term
);

	logic						live_q;
	logic						full_q;
	logic						can_load;
	logic						take;
	logic [`NB_NDATA-1:0]		raw_data;
	logic [`NB_NIDLE-1:0]		raw_idle;
	logic [`NB_TERM-1:0]		raw_term;
	logic [`NB_NDATA-1:0]		cl_data;
	logic [`NB_NIDLE-1:0]		cl_idle;

	// source select
	always_comb begin
		if (i_auto) begin
			raw_data = i_noise_word.fields.n_data;
			raw_idle = i_noise_word.fields.n_idle;
			raw_term = i_noise_word.fields.n_term;
		end else begin
			raw_data = i_desc_n_data;
			raw_idle = i_desc_n_idle;
			raw_term = i_desc_n_term;
		end
	end

	// clamp to at least one word, payload capped
	assign cl_data = (raw_data == '0) ? 8'd1 :
					 (raw_data > `NDATA_MAX) ? `NDATA_MAX : raw_data;
	assign cl_idle = (raw_idle == '0) ? 5'd1 : raw_idle;

	// slot frees on the same edge it is read
	assign can_load      = live_q & (~full_q | i_ready);
	assign o_noise_ready = i_auto & can_load;
	assign o_desc_ready  = ~i_auto & can_load;
	assign take          = i_auto ? (i_noise_valid & o_noise_ready)
								  : (i_desc_valid & o_desc_ready);

	assign o_valid = full_q;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			live_q <= 1'b0;
			full_q <= 1'b0;
		end else begin
			live_q <= 1'b1;	// keeps ready low during the reset cycle
			if (take) begin
				full_q <= 1'b1;
			end else if (i_ready) begin
				full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			o_n_data <= cl_data;
			o_n_idle <= cl_idle;
			o_n_term <= raw_term;	// any lane is legal
		end
	end

endmodule

`default_nettype wire

//--- source/frame_generator.sv
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module frame_generator (
	input  wire							i_clock,
	input  wire							i_rst_n,
	input  wire							i_par_valid,
	input  wire	[`NB_NDATA-1:0]			i_n_data,
	input  wire	[`NB_NIDLE-1:0]			i_n_idle,
	input  wire	[`NB_TERM-1:0]			i_n_term,
	input  wire							i_ready,
	output logic						o_par_ready,
	output logic [`NB_DATA_RAW-1:0]		o_tx_data,
	output logic [`NB_CTRL_RAW-1:0]		o_tx_ctrl,
	output logic						o_valid,
	output logic [`NB_NDATA-1:0]		o_n_data,
	output logic [`NB_NIDLE-1:0]		o_n_idle,
	output logic [`NB_TERM-1:0]			o_n_term
);

	logic [2:0]					state_q;
	logic [2:0]					state_d;
	logic [`NB_NDATA-1:0]		cnt_q;	// words sent in current section
	logic [`NB_NDATA-1:0]		cnt_d;
	logic [7:0]					byte_q;	// next payload byte value
	logic [7:0]					byte_d;
	logic [`NB_DATA_RAW-1:0]	data_d;
	logic [`NB_CTRL_RAW-1:0]	ctrl_d;
	logic						valid_d;
	logic						adv;
	logic						take;
	logic						last_idle;

	// eight lanes of the running payload count
	function automatic logic [`NB_DATA_RAW-1:0] payload_word(input logic [7:0] base);
		logic [`NB_DATA_RAW-1:0] w;
		for (int k = 0; k < `NB_CTRL_RAW; k++) begin
			w[8*k +: 8] = base + 8'(k);
		end
		return w;
	endfunction

	// payload below the terminate lane, idle above it
	function automatic logic [`NB_DATA_RAW-1:0] term_word(
		input logic [7:0]			base,
		input logic [`NB_TERM-1:0]	term
	);
		logic [`NB_DATA_RAW-1:0] w;
		for (int k = 0; k < `NB_CTRL_RAW; k++) begin
			if (k < int'(term)) begin
				w[8*k +: 8] = base + 8'(k);
			end else if (k == int'(term)) begin
				w[8*k +: 8] = `CH_TERM;
			end else begin
				w[8*k +: 8] = `CH_IDLE;
			end
		end
		return w;
	endfunction

	function automatic logic [`NB_CTRL_RAW-1:0] term_ctrl(input logic [`NB_TERM-1:0] term);
		logic [`NB_CTRL_RAW-1:0] c;
		for (int k = 0; k < `NB_CTRL_RAW; k++) begin
			c[k] = (k >= int'(term));	// control from terminate lane up
		end
		return c;
	endfunction

	assign adv       = o_valid & i_ready;
	assign last_idle = (state_q == `ST_IDLE) && (cnt_q == {3'b000, o_n_idle});

	// back to back frames when a descriptor waits
	assign o_par_ready = (state_q == `ST_WAIT) || (last_idle && i_ready);
	assign take        = i_par_valid & o_par_ready;

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		byte_d  = byte_q;
		data_d  = o_tx_data;
		ctrl_d  = o_tx_ctrl;
		valid_d = o_valid;
		if (take) begin
			state_d = `ST_START;
			data_d  = {`CH_SFD, {6{`CH_PRE}}, `CH_START};	// lane 0 holds start
			ctrl_d  = 8'h01;
			valid_d = 1'b1;
			cnt_d   = '0;
			byte_d  = '0;
		end else if (adv) begin
			case (state_q)
				`ST_START: begin
					state_d = `ST_DATA;
					data_d  = payload_word(byte_q);
					ctrl_d  = '0;
					byte_d  = byte_q + 8'd8;
					cnt_d   = 8'd1;
				end
				`ST_DATA: begin
					if (cnt_q == o_n_data) begin
						state_d = `ST_TERM;
						data_d  = term_word(byte_q, o_n_term);
						ctrl_d  = term_ctrl(o_n_term);
					end else begin
						data_d = payload_word(byte_q);
						byte_d = byte_q + 8'd8;
						cnt_d  = cnt_q + 8'd1;
					end
				end
				`ST_TERM: begin
					state_d = `ST_IDLE;
					data_d  = {`NB_CTRL_RAW{`CH_IDLE}};
					ctrl_d  = '1;
					cnt_d   = 8'd1;
				end
				`ST_IDLE: begin
					if (last_idle) begin
						state_d = `ST_WAIT;	// nothing queued
						valid_d = 1'b0;
					end else begin
						data_d = {`NB_CTRL_RAW{`CH_IDLE}};
						ctrl_d = '1;
						cnt_d  = cnt_q + 8'd1;
					end
				end
				default: begin
					state_d = `ST_WAIT;
					valid_d = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q  <= `ST_WAIT;
			cnt_q    <= '0;
			byte_q   <= '0;
			o_valid  <= 1'b0;
			o_n_data <= 8'd1;
			o_n_idle <= 5'd1;
			o_n_term <= '0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			byte_q  <= byte_d;
			o_valid <= valid_d;
			if (take) begin
				o_n_data <= i_n_data;	// held for the whole frame
				o_n_idle <= i_n_idle;
				o_n_term <= i_n_term;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		o_tx_data <= data_d;
		o_tx_ctrl <= ctrl_d;
	end

endmodule

`default_nettype wire

//--- source/frame_gen_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module frame_gen_top
	import frame_pkg::*;
(
	input  wire							i_clock,
	input  wire							i_rst_n,
	input  wire							i_auto,
	input  wire							i_desc_valid,
	input  wire	[`NB_NDATA-1:0]			i_desc_n_data,
	input  wire	[`NB_NIDLE-1:0]			i_desc_n_idle,
	input  wire	[`NB_TERM-1:0]			i_desc_n_term,
	output wire							o_desc_ready,
	output wire	[`NB_DATA_RAW-1:0]		o_tx_data,
	output wire	[`NB_CTRL_RAW-1:0]		o_tx_ctrl,
	output wire							o_valid,
	input  wire							i_ready,
	output wire	[`NB_NDATA-1:0]			o_n_data,
	output wire	[`NB_NIDLE-1:0]			o_n_idle,
	output wire	[`NB_TERM-1:0]			o_n_term
);

	wire						noise_valid;
	wire						noise_ready;
	noise_word_u				noise_word;
	wire						par_valid;
	wire						par_ready;
	wire [`NB_NDATA-1:0]		par_n_data;
	wire [`NB_NIDLE-1:0]		par_n_idle;
	wire [`NB_TERM-1:0]			par_n_term;

	noise_lfsr u_noise_lfsr (
		.i_clock	(i_clock),
		.i_rst_n	(i_rst_n),
		.i_ready	(noise_ready),
		.o_valid	(noise_valid),
		.o_word		(noise_word)
	);

	frame_param_shaper u_frame_param_shaper (
		.i_clock		(i_clock),
		.i_rst_n		(i_rst_n),
		.i_auto			(i_auto),
		.i_noise_valid	(noise_valid),
		.i_noise_word	(noise_word),
		.i_desc_valid	(i_desc_valid),
		.i_desc_n_data	(i_desc_n_data),
		.i_desc_n_idle	(i_desc_n_idle),
		.i_desc_n_term	(i_desc_n_term),
		.i_ready		(par_ready),
		.o_noise_ready	(noise_ready),
		.o_desc_ready	(o_desc_ready),
		.o_valid		(par_valid),
		.o_n_data		(par_n_data),
		.o_n_idle		(par_n_idle),
		.o_n_term		(par_n_term)
	);

	frame_generator u_frame_generator (
		.i_clock		(i_clock),
		.i_rst_n		(i_rst_n),
		.i_par_valid	(par_valid),
		.i_n_data		(par_n_data),
		.i_n_idle		(par_n_idle),
		.i_n_term		(par_n_term),
		.i_ready		(i_ready),
		.o_par_ready	(par_ready),
		.o_tx_data		(o_tx_data),
		.o_tx_ctrl		(o_tx_ctrl),
		.o_valid		(o_valid),
		.o_n_data		(o_n_data),
		.o_n_idle		(o_n_idle),
		.o_n_term		(o_n_term)
	);

endmodule

`default_nettype wire

//--- dv/frame_gen_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module frame_gen_chk (
	input  wire							i_clock,
	input  wire							i_rst_n,
	input  wire							i_auto,
	input  wire							i_desc_ready,
	input  wire	[`NB_DATA_RAW-1:0]		i_tx_data,
	input  wire	[`NB_CTRL_RAW-1:0]		i_tx_ctrl,
	input  wire							i_valid,
	input  wire							i_ready,
	input  wire	[`NB_NDATA-1:0]			i_n_data,
	input  wire	[`NB_NIDLE-1:0]			i_n_idle
);

	int fail_count = 0;	// read by the testbench at the end

	a_word_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_valid && !i_ready) |=> (i_valid && $stable(i_tx_data) && $stable(i_tx_ctrl)))
		else begin
			fail_count++;
			$error("output word changed while stalled");
		end

	a_ndata_range: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_n_data >= 8'd1) && (i_n_data <= `NDATA_MAX))
		else begin
			fail_count++;
			$error("o_n_data out of range");
		end

	a_nidle_nonzero: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_n_idle != '0)
		else begin
			fail_count++;
			$error("o_n_idle is zero");
		end

	a_auto_no_desc: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_auto |-> !i_desc_ready)
		else begin
			fail_count++;
			$error("o_desc_ready high in auto mode");
		end

endmodule

bind frame_gen_top frame_gen_chk chk_i (
	.i_clock		(i_clock),
	.i_rst_n		(i_rst_n),
	.i_auto			(i_auto),
	.i_desc_ready	(o_desc_ready),
	.i_tx_data		(o_tx_data),
	.i_tx_ctrl		(o_tx_ctrl),
	.i_valid		(o_valid),
	.i_ready		(i_ready),
	.i_n_data		(o_n_data),
	.i_n_idle		(o_n_idle)
);

`default_nettype wire

//--- dv/frame_gen_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "frame_consts.svh"

module frame_gen_tb;

	localparam int N_DESC      = 17;
	localparam int AUTO_CYCLES = 600;

	logic			i_clock;
	logic			i_rst_n;
	logic			i_auto;
	logic			i_desc_valid;
	logic [7:0]		i_desc_n_data;
	logic [4:0]		i_desc_n_idle;
	logic [2:0]		i_desc_n_term;
	logic			i_ready;
	wire			o_desc_ready;
	wire [63:0]		o_tx_data;
	wire [7:0]		o_tx_ctrl;
	wire			o_valid;
	wire [7:0]		o_n_data;
	wire [4:0]		o_n_idle;
	wire [2:0]		o_n_term;

	logic [39:0]	desc_mem [0:N_DESC-1];	// n_data, n_idle, n_term, ready pattern
	logic [63:0]	q_data [$];
	logic [7:0]		q_ctrl [$];
	logic [15:0]	q_frame [$];	// frame index of each expected word
	logic [7:0]		q_nd [$];
	logic [4:0]		q_ni [$];
	logic [2:0]		q_nt [$];
	logic [31:0]	rnd_state = 32'hf6f58f60;
	int				mismatches = 0;
	int				others = 0;
	int				cycles = 0;
	int				limit = 0;
	int				desc_idx = 0;
	int				auto_cnt = 0;
	int				auto_frames = 0;	// frames finished in auto mode
	int				total_words = 0;
	int				head_frame;
	logic [15:0]	pat;
	logic			gap_ok;

	frame_gen_top dut_i (.*);

	function automatic logic next_rand_bit();
		logic fb;
		fb = rnd_state[31] ^ rnd_state[21] ^ rnd_state[1] ^ rnd_state[0];
		rnd_state = {rnd_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] clamp_data(input logic [7:0] raw);
		if (raw == 8'd0)
			return 8'd1;
		else if (raw > 8'd189)
			return 8'd189;
		return raw;
	endfunction

	function automatic logic [4:0] clamp_idle(input logic [4:0] raw);
		return (raw == 5'd0) ? 5'd1 : raw;
	endfunction

	task automatic push_word(input logic [63:0] d, input logic [7:0] c, input int f,
		input logic [7:0] nd, input logic [4:0] ni, input logic [2:0] nt);
		q_data.push_back(d);
		q_ctrl.push_back(c);
		q_frame.push_back(16'(f));
		q_nd.push_back(nd);
		q_ni.push_back(ni);
		q_nt.push_back(nt);
	endtask

	// whole expected frame from the format rules
	task automatic push_frame(input logic [7:0] nd, input logic [4:0] ni,
		input logic [2:0] nt, input int f);
		logic [63:0] w;
		logic [7:0] c;
		push_word(64'hD5555555555555FB, 8'h01, f, nd, ni, nt);
		for (int i = 0; i < nd; i++) begin
			for (int k = 0; k < 8; k++)
				w[8*k +: 8] = 8'((i * 8 + k) % 256);
			push_word(w, 8'h00, f, nd, ni, nt);
		end
		for (int k = 0; k < 8; k++) begin
			if (k < nt)
				w[8*k +: 8] = 8'((nd * 8 + k) % 256);
			else
				w[8*k +: 8] = (k == nt) ? 8'hFD : 8'h07;
			c[k] = (k >= nt);
		end
		push_word(w, c, f, nd, ni, nt);
		for (int i = 0; i < ni; i++)
			push_word({8{8'h07}}, 8'hFF, f, nd, ni, nt);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word();
		if (i_auto && q_data.size() == 0) begin
			assert (o_n_data >= 8'd1 && o_n_data <= 8'd189 && o_n_idle != 5'd0) else begin
				others++;
				$display("auto frame at t=%0t reports descriptor out of range", $time);
			end
			push_frame(o_n_data, o_n_idle, o_n_term, N_DESC);
		end
		assert (q_data.size() != 0) else begin
			others++;
			$display("word transferred at t=%0t when no word was expected", $time);
		end
		if (q_data.size() != 0) begin
			check_value("o_tx_data", o_tx_data, q_data.pop_front());
			check_value("o_tx_ctrl", 64'(o_tx_ctrl), 64'(q_ctrl.pop_front()));
			check_value("o_n_data", 64'(o_n_data), 64'(q_nd.pop_front()));
			check_value("o_n_idle", 64'(o_n_idle), 64'(q_ni.pop_front()));
			check_value("o_n_term", 64'(o_n_term), 64'(q_nt.pop_front()));
			void'(q_frame.pop_front());
			if (i_auto && q_data.size() == 0)
				auto_frames++;
		end
	endtask

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	// run limit from the length of all frames
	initial begin
		wait (limit != 0);
		while (cycles <= limit) begin
			@(posedge i_clock);
			cycles++;
		end
		$display("timeout after %0d cycles, output stream stopped", cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		i_rst_n       = 1'b0;
		i_auto        = 1'b0;
		i_desc_valid  = 1'b0;
		i_desc_n_data = '0;
		i_desc_n_idle = '0;
		i_desc_n_term = '0;
		i_ready       = 1'b0;
		$readmemh("dv/frame_gen_testdata.txt", desc_mem);
		for (int i = 0; i < N_DESC; i++)
			total_words += 2 + clamp_data(desc_mem[i][39:32]) + clamp_idle(desc_mem[i][28:24]);
		limit = total_words * 4 + AUTO_CYCLES + 200;
		repeat (10) @(posedge i_clock);
		@(negedge i_clock);
		i_rst_n = 1'b1;
		while (auto_cnt < AUTO_CYCLES) begin
			@(negedge i_clock);
			if (!i_auto && desc_idx == N_DESC && q_data.size() == 0)
				i_auto = 1'b1;	// external frames all out
			i_desc_valid = !i_auto && (desc_idx < N_DESC);
			if (i_desc_valid) begin
				i_desc_n_data = desc_mem[desc_idx][39:32];
				i_desc_n_idle = desc_mem[desc_idx][28:24];
				i_desc_n_term = desc_mem[desc_idx][18:16];
			end
			head_frame = (q_frame.size() != 0) ? int'(q_frame[0]) : N_DESC;
			pat = (head_frame < N_DESC) ? desc_mem[head_frame][15:0] : 16'h7fff;
			gap_ok = (pat == 16'hffff) ? 1'b1 : (next_rand_bit() | next_rand_bit());
			i_ready = pat[cycles % 16] & gap_ok;
			if (i_auto)
				auto_cnt++;
			#1;
			if (i_desc_valid && o_desc_ready) begin
				push_frame(clamp_data(i_desc_n_data), clamp_idle(i_desc_n_idle),
					i_desc_n_term, desc_idx);
				desc_idx++;
			end
			if (o_valid && i_ready)
				check_word();
		end
		assert (auto_frames != 0) else begin
			others++;
			$display("no complete frame was sent in auto mode");
		end
		others += dut_i.chk_i.fail_count;
		$display("errors: mismatches=%0d other=%0d", mismatches, others);
		if (mismatches == 0 && others == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/frame_gen_testdata.txt
// columns: raw n_data (8b) _ raw n_idle (5b) _ n_term (3b) _ i_ready pattern (16b)
// ready pattern ffff means no gaps, other patterns add random gaps
03_02_04_ffff
05_03_02_ffff
00_04_01_ffff
ff_02_05_ffff
06_00_03_ffff
02_01_00_ffff
02_01_01_ffff
02_02_02_ffff
02_01_03_ffff
02_03_04_ffff
02_01_05_ffff
02_02_06_ffff
02_01_07_ffff
04_03_06_7777
0a_05_02_bbbb
08_00_07_feff
bf_02_03_ed7b

//--- build.f
+incdir+source
source/frame_pkg.sv
source/noise_lfsr.sv
source/frame_param_shaper.sv
source/frame_generator.sv
source/frame_gen_top.sv
dv/frame_gen_chk.sv
dv/frame_gen_tb.sv

//--- Bender.yml
package:
  name: frame_gen

sources:
  - include_dirs:
      - source
    files:
      - source/frame_pkg.sv
      - source/noise_lfsr.sv
      - source/frame_param_shaper.sv
      - source/frame_generator.sv
      - source/frame_gen_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/frame_gen_chk.sv
      - dv/frame_gen_tb.sv
